/* data_ram.sv */
module data_ram #(
    parameter int RAM_WORDS = 64
) (
    input  logic              clk,
    input  lsu_pkg::addr_t    addr,
    input  logic              we,
    input  lsu_pkg::byte_en_t be,
    input  lsu_pkg::data_t    wdata,
    output lsu_pkg::data_t    rdata
);

    localparam int IDX_W = (RAM_WORDS > 1) ? $clog2(RAM_WORDS) : 1;
    localparam int LANES = $bits(lsu_pkg::byte_en_t);

    lsu_pkg::data_t   mem [RAM_WORDS];
    logic [IDX_W-1:0] word_idx;

    // Upper address bits wrap around the RAM depth
    assign word_idx = IDX_W'((addr >> 2) % RAM_WORDS);

    initial begin
        for (int i = 0; i < RAM_WORDS; i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge clk) begin
        for (int lane = 0; lane < LANES; lane++) begin
            if (we && be[lane]) begin
                mem[word_idx][lane*8 +: 8] <= wdata[lane*8 +: 8];
            end
        end
        // Read-first, a write cycle returns the old word
        rdata <= mem[word_idx];
    end

endmodule

/* filelist.f */
lsu_pkg.sv
mem_align.sv
data_ram.sv
lsu_ctrl.sv
lsu_top.sv
tb_lsu.sv

/* lsu_ctrl.sv */
module lsu_ctrl (
    input  logic              clk,
    input  logic              rst,
    input  logic              req_valid,
    output logic              req_ready,
    input  lsu_pkg::lsu_req_t req,
    output logic              rsp_valid,
    input  logic              rsp_ready,
    output lsu_pkg::lsu_rsp_t rsp,
    output lsu_pkg::lsu_req_t cur_req,
    input  lsu_pkg::byte_en_t byte_en,
    input  lsu_pkg::data_t    store_data,
    input  logic              fault,
    input  lsu_pkg::data_t    load_data,
    output logic              ram_we,
    output lsu_pkg::byte_en_t ram_be,
    output lsu_pkg::data_t    ram_wdata
);

    typedef enum logic [1:0] {
        st_idle,
        st_access,
        st_resp
    } state_t;

    state_t state;
    state_t state_next;
    logic   accept;
    logic   rsp_fire;
    logic   rsp_load;

    assign req_ready = (state == st_idle);
    assign accept    = req_valid && req_ready;
    assign rsp_fire  = rsp_valid && rsp_ready;

    // First cycle of st_resp, read word is valid here
    assign rsp_load = (state == st_resp) && !rsp_valid;

    always_comb begin
        state_next = state;
        case (state)
            st_idle: begin
                if (accept) begin
                    state_next = st_access;
                end
            end
            st_access: begin
                state_next = st_resp;
            end
            st_resp: begin
                if (rsp_fire) begin
                    state_next = st_idle;
                end
            end
            default: begin
                state_next = st_idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= st_idle;
            rsp_valid <= 1'b0;
        end else begin
            state <= state_next;
            if (rsp_load) begin
                rsp_valid <= 1'b1;
            end else if (rsp_fire) begin
                rsp_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            cur_req <= req;
        end
        if (rsp_load) begin
            rsp.fault <= fault;
            rsp.rdata <= (cur_req.is_store || fault) ? '0 : load_data;
        end
    end

    // Single write cycle, refused accesses never reach the RAM
    assign ram_we    = (state == st_access) && cur_req.is_store && !fault;
    assign ram_be    = ram_we ? byte_en : '0;
    assign ram_wdata = store_data;

    // Response held under back-pressure
    property p_rsp_hold;
        @(posedge clk) disable iff (rst)
            rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp);
    endproperty
    a_rsp_hold: assert property (p_rsp_hold);

    // RAM writes never overlap a pending response
    property p_we_access;
        @(posedge clk) disable iff (rst)
            ram_we |-> !rsp_valid;
    endproperty
    a_we_access: assert property (p_we_access);

endmodule

/* lsu_pkg.sv */
package lsu_pkg;

    // Byte address as issued by the client
    typedef logic [31:0] addr_t;

    typedef logic [31:0] data_t;

    // One bit per byte lane of a data word
    typedef logic [3:0] byte_en_t;

    // Bit 2 is the unsigned flag, bits 1:0 the access size
    typedef logic [2:0] funct3_t;

    // Access size from funct3[1:0], code 3 unused
    typedef enum logic [1:0] {
        size_byte = 2'd0,
        size_half = 2'd1,
        size_word = 2'd2
    } xfer_size_t;

    typedef struct packed {
        logic    is_store;
        funct3_t funct3;
        addr_t   addr;
        data_t   wdata;
    } lsu_req_t;

    // rdata is zero for stores and faults
    typedef struct packed {
        data_t rdata;
        logic  fault;
    } lsu_rsp_t;

endpackage

/* lsu_top.sv */
module lsu_top #(
    parameter int RAM_WORDS = 64
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              req_valid,
    output logic              req_ready,
    input  lsu_pkg::lsu_req_t req,
    output logic              rsp_valid,
    input  logic              rsp_ready,
    output lsu_pkg::lsu_rsp_t rsp
);

    lsu_pkg::lsu_req_t cur_req;
    lsu_pkg::byte_en_t byte_en;
    lsu_pkg::byte_en_t ram_be;
    lsu_pkg::data_t    store_data;
    lsu_pkg::data_t    load_data;
    lsu_pkg::data_t    ram_wdata;
    lsu_pkg::data_t    rword;
    logic              fault;
    logic              ram_we;

    lsu_ctrl u_ctrl (
        .clk        (clk),
        .rst        (rst),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .req        (req),
        .rsp_valid  (rsp_valid),
        .rsp_ready  (rsp_ready),
        .rsp        (rsp),
        .cur_req    (cur_req),
        .byte_en    (byte_en),
        .store_data (store_data),
        .fault      (fault),
        .load_data  (load_data),
        .ram_we     (ram_we),
        .ram_be     (ram_be),
        .ram_wdata  (ram_wdata)
    );

    mem_align u_align (
        .req        (cur_req),
        .rword      (rword),
        .load_data  (load_data),
        .byte_en    (byte_en),
        .store_data (store_data),
        .fault      (fault)
    );

    // Word index comes from the held request address
    data_ram #(
        .RAM_WORDS (RAM_WORDS)
    ) u_ram (
        .clk   (clk),
        .addr  (cur_req.addr),
        .we    (ram_we),
        .be    (ram_be),
        .wdata (ram_wdata),
        .rdata (rword)
    );

endmodule

/* mem_align.sv */
module mem_align (
    input  lsu_pkg::lsu_req_t req,
    input  lsu_pkg::data_t    rword,
    output lsu_pkg::data_t    load_data,
    output lsu_pkg::byte_en_t byte_en,
    output lsu_pkg::data_t    store_data,
    output logic              fault
);

    lsu_pkg::xfer_size_t size;
    logic [1:0]          offset;
    logic                sign_ext;
    lsu_pkg::data_t      lane;
    lsu_pkg::data_t      extended;
    lsu_pkg::byte_en_t   lane_mask;
    logic                misaligned;
    logic                bad_size;
    logic                bad_store;

    assign size     = lsu_pkg::xfer_size_t'(req.funct3[1:0]);
    assign offset   = req.addr[1:0];
    assign sign_ext = ~req.funct3[2];

    // Addressed data moved down to lane 0
    assign lane = rword >> {offset, 3'b000};

    // Load extraction and extension
    always_comb begin
        case (size)
            lsu_pkg::size_byte: begin
                extended = {{24{sign_ext & lane[7]}}, lane[7:0]};
            end
            lsu_pkg::size_half: begin
                extended = {{16{sign_ext & lane[15]}}, lane[15:0]};
            end
            lsu_pkg::size_word: begin
                extended = rword;
            end
            default: begin
                extended = '0;
            end
        endcase
    end

    // Store replication and lane mask
    always_comb begin
        case (size)
            lsu_pkg::size_byte: begin
                store_data = {4{req.wdata[7:0]}};
                lane_mask  = 4'b0001 << offset;
            end
            lsu_pkg::size_half: begin
                store_data = {2{req.wdata[15:0]}};
                lane_mask  = 4'b0011 << offset;
            end
            lsu_pkg::size_word: begin
                store_data = req.wdata;
                lane_mask  = 4'b1111;
            end
            default: begin
                store_data = '0;
                lane_mask  = '0;
            end
        endcase
    end

    // Alignment and encoding checks
    always_comb begin
        misaligned = 1'b0;
        bad_size   = 1'b0;
        case (size)
            lsu_pkg::size_byte: begin
                misaligned = 1'b0;
            end
            lsu_pkg::size_half: begin
                misaligned = offset[0];
            end
            lsu_pkg::size_word: begin
                misaligned = (offset != 2'b00);
            end
            default: begin
                bad_size = 1'b1;
            end
        endcase
    end

    // No unsigned form exists for stores
    assign bad_store = req.is_store & req.funct3[2];

    assign fault     = misaligned | bad_size | bad_store;
    assign byte_en   = fault ? '0 : lane_mask;
    assign load_data = fault ? '0 : extended;

endmodule

/* run.sh */
#!/bin/sh
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
    --timescale 1ns/1ps \
    --top-module tb_lsu \
    -f filelist.f \
    -o Vtb_lsu

output=$(./obj_dir/Vtb_lsu 2>&1) || true
echo "$output"

if echo "$output" | grep -q "RESULT: PASS"; then
    exit 0
fi
echo "Simulation did not pass"
exit 1

/* tb_lsu.sv */
module tb_lsu;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int RAM_WORDS      = 64;
    localparam int N_ACCESS       = 400;
    localparam int TIMEOUT_CYCLES = N_ACCESS * 12;

    logic              clk;
    logic              rst;
    logic              req_valid;
    logic              req_ready;
    lsu_pkg::lsu_req_t req;
    logic              rsp_valid;
    logic              rsp_ready;
    lsu_pkg::lsu_rsp_t rsp;

    integer      seed;
    int          cycle_count = 0;
    logic [31:0] shadow [RAM_WORDS];

    lsu_top #(
        .RAM_WORDS (RAM_WORDS)
    ) dut0 (
        .clk       (clk),
        .rst       (rst),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .req       (req),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .rsp       (rsp)
    );

    initial begin
        clk = 1'b0;
    end

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("RESULT: FAIL");
            $fatal(1, "Simulation timed out");
        end
    end

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("[ERROR] %0t ns: %s: got %h, expected %h", $time, what, actual, expected);
            $display("RESULT: FAIL");
            $fatal(1, "Stopped at the first mismatch");
        end
    endtask

    // Word address wraps at the RAM depth
    function automatic int word_index(input logic [31:0] addr);
        return int'(addr[31:2]) % RAM_WORDS;
    endfunction

    function automatic logic expect_fault(input lsu_pkg::lsu_req_t r);
        logic [1:0] size;
        logic [1:0] off;
        size = r.funct3[1:0];
        off  = r.addr[1:0];
        if (size == 2'd3) begin
            return 1'b1;
        end
        if (r.is_store && r.funct3[2]) begin
            return 1'b1;
        end
        if (size == 2'd1 && off[0]) begin
            return 1'b1;
        end
        if (size == 2'd2 && off != 2'd0) begin
            return 1'b1;
        end
        return 1'b0;
    endfunction

    // Only called for accesses that do not fault
    function automatic logic [31:0] expect_load(input lsu_pkg::lsu_req_t r);
        logic [31:0] word;
        logic [7:0]  b;
        logic [15:0] h;
        int          off;
        word = shadow[word_index(r.addr)];
        off  = int'(r.addr[1:0]);
        b    = word[off * 8 +: 8];
        h    = word[(off & 2) * 8 +: 16];
        case (r.funct3[1:0])
            2'd0: return r.funct3[2] ? {24'b0, b} : {{24{b[7]}}, b};
            2'd1: return r.funct3[2] ? {16'b0, h} : {{16{h[15]}}, h};
            default: return word;
        endcase
    endfunction

    // Store data byte k lands in lane off + k
    function automatic void write_shadow(input lsu_pkg::lsu_req_t r);
        int idx;
        int nbytes;
        int off;
        idx    = word_index(r.addr);
        nbytes = 1 << r.funct3[1:0];
        off    = int'(r.addr[1:0]);
        for (int k = 0; k < nbytes; k++) begin
            shadow[idx][(off + k) * 8 +: 8] = r.wdata[k * 8 +: 8];
        end
    endfunction

    task automatic run_access(input lsu_pkg::lsu_req_t r, input int n);
        lsu_pkg::lsu_rsp_t exp_rsp;
        logic              fire;
        exp_rsp.fault = expect_fault(r);
        exp_rsp.rdata = (r.is_store || exp_rsp.fault) ? 32'b0 : expect_load(r);
        req_valid = 1'b1;
        req       = r;
        while (!req_ready) begin
            @(posedge clk);
            #2;
        end
        // Accept edge
        @(posedge clk);
        #2;
        req_valid    = 1'b0;
        req.is_store = 1'($random(seed));
        req.funct3   = 3'($random(seed));
        req.addr     = $random(seed);
        req.wdata    = $random(seed);
        if (r.is_store && !exp_rsp.fault) begin
            write_shadow(r);
        end
        check_value(32'(rsp_valid), 32'd0, $sformatf("access %0d rsp_valid in access", n));
        check_value(32'(req_ready), 32'd0, $sformatf("access %0d req_ready in access", n));
        @(posedge clk);
        #2;
        check_value(32'(rsp_valid), 32'd0, $sformatf("access %0d rsp_valid early", n));
        @(posedge clk);
        #2;
        fire = 1'b0;
        while (!fire) begin
            rsp_ready = ($random(seed) % 3) != 0;
            check_value(32'(rsp_valid), 32'd1, $sformatf("access %0d rsp_valid", n));
            check_value(32'(req_ready), 32'd0, $sformatf("access %0d req_ready in resp", n));
            check_value(rsp.rdata, exp_rsp.rdata, $sformatf("access %0d rdata", n));
            check_value(32'(rsp.fault), 32'(exp_rsp.fault), $sformatf("access %0d fault", n));
            fire = rsp_ready;
            @(posedge clk);
            #2;
        end
        rsp_ready = 1'b0;
        check_value(32'(rsp_valid), 32'd0, $sformatf("access %0d rsp_valid after", n));
        check_value(32'(req_ready), 32'd1, $sformatf("access %0d req_ready after", n));
    endtask

    initial begin
        lsu_pkg::lsu_req_t r;
        logic              prev_store;
        logic [31:0]       prev_addr;
        seed      = 18;
        rst       = 1'b1;
        req_valid = 1'b0;
        req       = '0;
        rsp_ready = 1'b0;
        for (int i = 0; i < RAM_WORDS; i++) begin
            shadow[i] = 32'b0;
        end
        repeat (3) @(posedge clk);
        #2;
        rst = 1'b0;
        check_value(32'(req_ready), 32'd1, "req_ready after reset");
        check_value(32'(rsp_valid), 32'd0, "rsp_valid after reset");

        prev_store = 1'b0;
        prev_addr  = 32'b0;
        for (int i = 0; i < N_ACCESS; i++) begin
            if (prev_store) begin
                // Read back the whole word a store just touched
                r.is_store = 1'b0;
                r.funct3   = 3'b010;
                r.addr     = {prev_addr[31:2], 2'b00};
                r.wdata    = $random(seed);
            end else begin
                r.is_store = 1'($random(seed));
                r.funct3   = 3'($random(seed));
                r.addr     = $random(seed) & 32'h0000_00ff;
                r.wdata    = $random(seed);
            end
            run_access(r, i);
            prev_store = r.is_store;
            prev_addr  = r.addr;
        end

        $display("RESULT: PASS");
        $finish;
    end

endmodule
